/* src.f */
+incdir+include
src/routing_pkg.sv
src/mem_if.sv
src/feedback_rx.sv
src/record_fifo.sv
src/learn_costs.sv
src/node_mem.sv
src/routing_top.sv
verif/tb_clock.sv
verif/routing_asserts.sv
verif/routing_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the routing table testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module routing_tb -o sim_routing &&
./obj_dir/sim_routing | tee /dev/stderr | grep "TB PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verif/routing_tb.sv */
`timescale 1ns/1ps
`include "mem_map.svh"

module routing_tb;
	import routing_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int NUM_FRAMES = 21;
	localparam int TIMEOUT = NUM_FRAMES * 200 + 1000;
	localparam int TABLE_END = 'h70E; // end of the last sink count slot

	logic clock, nrst, rx_valid, rx_sof, host_wr, busy, done, overflow;
	word_t rx_word, epsilon_init, host_wdata, host_rdata;
	logic [10:0] host_addr;

	word_t model [1024]; // table copy, one entry per word
	feedback_t sent_q [$]; // frames waiting for their push
	feedback_t accepted_q [$]; // pushed into the FIFO, not yet modelled
	int fcount; // predicted FIFO occupancy
	int lost;
	logic push_pending, track, pop_next;
	int errors, cycles;
	integer seed;

	tb_clock #(.PERIOD(100.0)) clk_gen (.clock(clock));

	routing_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
		.clock(clock), .nrst(nrst), .rx_valid(rx_valid), .rx_sof(rx_sof),
		.rx_word(rx_word), .epsilon_init(epsilon_init), .host_addr(host_addr),
		.host_wr(host_wr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.busy(busy), .done(done), .overflow(overflow)
	);

	function automatic word_t model_rd(input int addr);
		return model[addr / 2];
	endfunction

	function automatic void model_wr(input int addr, input word_t val);
		model[addr / 2] = val;
	endfunction

	// reference update for one record
	function automatic void apply_frame(input feedback_t f);
		int ncnt;
		int kcnt;
		int slot;
		bit found;
		ncnt = model_rd(`NEIGHBOR_COUNT_ADDR);
		kcnt = model_rd(`KNOWN_SINK_COUNT_ADDR);
		if (ncnt > MAX_NEIGHBORS)
			ncnt = MAX_NEIGHBORS;
		if (kcnt > MAX_SINKS)
			kcnt = MAX_SINKS;
		found = 0;
		slot = 0;
		for (int n = 0; n < ncnt; n++) begin
			if (!found && model_rd(`NEIGHBOR_ID_BASE + 2 * n) == f.source_id) begin
				found = 1;
				slot = n;
			end
		end
		if (!found && ncnt == MAX_NEIGHBORS)
			return; // full table, unknown source
		if (!found) begin
			slot = ncnt;
			model_wr(`NEIGHBOR_ID_BASE + 2 * slot, f.source_id);
			model_wr(`QVALUE_BASE + 2 * slot, f.value);
			model_wr(`CLUSTER_ID_BASE + 2 * slot, f.cluster_id);
		end
		model_wr(`BATTERY_BASE + 2 * slot, f.battery_stat);
		for (int k = 0; k < kcnt; k++)
			model_wr(`SINK_IDS_BASE + 16 * slot + 2 * k, model_rd(`KNOWN_SINKS_BASE + 2 * k));
		model_wr(`SINK_ID_COUNT_BASE + 2 * slot, word_t'(kcnt));
		if (found) begin
			if (model_rd(`QVALUE_BASE + 2 * slot) < f.value)
				model_wr(`EPSILON_ADDR, epsilon_init);
		end else begin
			model_wr(`NEIGHBOR_COUNT_ADDR, word_t'(ncnt + 1));
		end
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// one clock, then FIFO occupancy bookkeeping for the edge just passed
	task automatic tick();
		int push_ok;
		feedback_t f;
		@(posedge clock);
		#10;
		if (track) begin
			push_ok = 0;
			if (push_pending) begin
				f = sent_q.pop_front();
				if (fcount < FIFO_DEPTH) begin
					accepted_q.push_back(f);
					push_ok = 1;
				end else begin
					lost++;
				end
			end
			fcount = fcount + push_ok - int'(pop_next);
			pop_next = !busy && !done && fcount > 0; // idle engine pops at the next edge
			push_pending = 1'b0;
		end
	endtask

	task automatic send_word(input logic sof, input word_t w);
		rx_valid = 1'b1;
		rx_sof = sof;
		rx_word = w;
		tick();
		rx_valid = 1'b0;
		rx_sof = 1'b0;
	endtask

	task automatic send_frame(input feedback_t f);
		sent_q.push_back(f);
		send_word(1'b1, f.source_id);
		send_word(1'b0, f.battery_stat);
		send_word(1'b0, f.value);
		send_word(1'b0, f.cluster_id);
		push_pending = 1'b1; // strobe lands in the next cycle
	endtask

	task automatic host_write(input int addr, input word_t val);
		host_addr = 11'(addr);
		host_wdata = val;
		host_wr = 1'b1;
		tick();
		host_wr = 1'b0;
		model_wr(addr, val);
	endtask

	task automatic apply_accepted();
		while (accepted_q.size() > 0)
			apply_frame(accepted_q.pop_front());
	endtask

	task automatic wait_done();
		do
			tick();
		while (!done);
		check_flag("busy", busy, 1'b0); // busy falls with done
		apply_accepted();
	endtask

	task automatic settle();
		do
			tick();
		while (fcount != 0 || busy || done || push_pending);
		apply_accepted();
	endtask

	// combinational host reads, all inside one quiet cycle
	task automatic compare_table();
		for (int a = 0; a < TABLE_END; a += 2) begin
			host_addr = 11'(a);
			#0.05;
			check_word($sformatf("table[%03h]", a), host_rdata, model_rd(a));
		end
	endtask

	function automatic feedback_t make_frame(input word_t src, input word_t bat,
			input word_t val, input word_t cl);
		return {src, bat, val, cl};
	endfunction

	initial begin
		cycles = 0;
		while (cycles <= TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, the updates did not finish", cycles);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed = 5;
		errors = 0;
		fcount = 0;
		lost = 0;
		track = 1'b0;
		push_pending = 1'b0;
		pop_next = 1'b0;
		nrst = 1'b0;
		rx_valid = 1'b0;
		rx_sof = 1'b0;
		rx_word = '0;
		epsilon_init = 16'h0777;
		host_addr = '0;
		host_wr = 1'b0;
		host_wdata = '0;
		repeat (2) @(posedge clock);
		#10;
		nrst = 1'b1;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("overflow", overflow, 1'b0);
		track = 1'b1;

		for (int a = 0; a < TABLE_END; a += 2)
			host_write(a, {a[10:0], 5'h15}); // address dependent fill
		host_write(`KNOWN_SINK_COUNT_ADDR, 16'd3);
		for (int k = 0; k < 3; k++)
			host_write(`KNOWN_SINKS_BASE + 2 * k, 16'h5100 + word_t'(k));
		host_write(`NEIGHBOR_COUNT_ADDR, 16'd4);
		for (int i = 0; i < 4; i++)
			host_write(`NEIGHBOR_ID_BASE + 2 * i, 16'h0A00 + word_t'(i));
		host_write(`QVALUE_BASE, 16'h0100);
		host_write(`QVALUE_BASE + 2, 16'h9000);

		send_frame(make_frame(16'hB123, 16'($random(seed)), 16'h0200, 16'($random(seed))));
		wait_done(); // new neighbor appended
		compare_table();

		host_write(`EPSILON_ADDR, 16'h1111);
		send_frame(make_frame(16'h0A00, 16'($random(seed)), 16'h0500, 16'h0001));
		wait_done(); // low stored q restores epsilon
		compare_table();

		host_write(`EPSILON_ADDR, 16'h1234);
		host_write(`KNOWN_SINK_COUNT_ADDR, 16'd11);
		for (int k = 3; k < 11; k++)
			host_write(`KNOWN_SINKS_BASE + 2 * k, 16'h5100 + word_t'(k));
		send_frame(make_frame(16'h0A01, 16'($random(seed)), 16'h1000, 16'h0002));
		wait_done(); // clamped sink list, epsilon kept
		compare_table();

		for (int i = 0; i < 4; i++) begin
			if ($random(seed) & 1)
				send_frame(make_frame(16'h0A00 + 16'($random(seed) & 3),
					16'($random(seed)), 16'($random(seed)), 16'($random(seed))));
			else
				send_frame(make_frame(16'hB000 | 16'($random(seed) & 'hFFF),
					16'($random(seed)), 16'($random(seed)), 16'($random(seed))));
			wait_done();
			compare_table();
		end

		send_word(1'b1, 16'h0DDD); // partial frame, dropped by restart
		send_word(1'b0, 16'h0001);
		send_frame(make_frame(16'h0A02, 16'h00AA, 16'h7000, 16'h0003));
		wait_done();
		repeat (40) tick();
		check_flag("busy", busy, 1'b0);
		compare_table();

		host_write(`NEIGHBOR_COUNT_ADDR, 16'd64);
		for (int i = 0; i < MAX_NEIGHBORS; i++)
			host_write(`NEIGHBOR_ID_BASE + 2 * i, 16'h0A00 + word_t'(i));
		send_frame(make_frame(16'hC000, 16'h0BBB, 16'h0CCC, 16'h0DDD));
		wait_done(); // full table ignores the stranger
		compare_table();

		for (int i = 0; i < 12; i++)
			send_frame(make_frame(16'h0A00 + 16'($random(seed) & 63),
				16'($random(seed)), 16'($random(seed)), 16'($random(seed))));
		settle();
		check_flag("overflow", overflow, lost > 0);
		compare_table();

		$display("errors: %0d, frames lost: %0d", errors, lost);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

/* verif/routing_asserts.sv */
`timescale 1ns/1ps

module routing_asserts (
	input logic clock,
	input logic nrst,
	input logic pop,
	input logic busy,
	input logic done,
	input logic wr_en,
	input logic push,
	input logic full,
	input logic overflow
);
	done_one_cycle: assert property (@(posedge clock) disable iff (!nrst) done |=> !done)
		else $error("done held longer than one cycle");
	pop_starts_busy: assert property (@(posedge clock) disable iff (!nrst) pop |=> busy)
		else $error("busy did not rise after pop");
	full_push_flagged: assert property (@(posedge clock) disable iff (!nrst)
		push && full |=> overflow)
		else $error("push into full FIFO without overflow");
	wr_low_after_reset: assert property (@(posedge clock) !nrst |=> !wr_en)
		else $error("write strobe high after reset");
endmodule

bind learn_costs routing_asserts consumer_checks (
	.clock(clock), .nrst(nrst), .pop(pop), .busy(busy), .done(done),
	.wr_en(mem.wr_en), .push(1'b0), .full(1'b0), .overflow(1'b0)
);

bind record_fifo routing_asserts buffer_checks (
	.clock(clock), .nrst(nrst), .pop(1'b0), .busy(1'b0), .done(1'b0),
	.wr_en(1'b0), .push(push), .full(full), .overflow(overflow)
);

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 100.0
) (
	output logic clock
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock; // free running
	end
endmodule

/* src/routing_top.sv */
`timescale 1ns/1ps

module routing_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic               clock,
	input  logic               nrst,
	input  logic               rx_valid,
	input  logic               rx_sof,
	input  routing_pkg::word_t rx_word,
	input  routing_pkg::word_t epsilon_init,
	input  logic [10:0]        host_addr,
	input  logic               host_wr,
	input  routing_pkg::word_t host_wdata,
	output routing_pkg::word_t host_rdata,
	output logic               busy,
	output logic               done,
	output logic               overflow
);
	import routing_pkg::*;

	feedback_t rx_record;
	feedback_t fifo_head;
	logic rx_push;
	logic fifo_not_empty;
	logic fifo_pop;

	mem_if table_port ();

	feedback_rx u_rx (
		.clock    (clock),
		.nrst     (nrst),
		.rx_valid (rx_valid),
		.rx_sof   (rx_sof),
		.rx_word  (rx_word),
		.push     (rx_push),
		.record   (rx_record)
	);

	record_fifo #(
		.DEPTH     (FIFO_DEPTH),
		.payload_t (feedback_t)
	) u_fifo (
		.clock     (clock),
		.nrst      (nrst),
		.push      (rx_push),
		.push_data (rx_record),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.not_empty (fifo_not_empty),
		.overflow  (overflow)
	);

	learn_costs u_learn (
		.clock        (clock),
		.nrst         (nrst),
		.not_empty    (fifo_not_empty),
		.head         (fifo_head),
		.epsilon_init (epsilon_init),
		.pop          (fifo_pop),
		.mem          (table_port.ctrl),
		.busy         (busy),
		.done         (done)
	);

	node_mem u_mem (
		.clock      (clock),
		.mem        (table_port.mem),
		.host_addr  (host_addr),
		.host_wr    (host_wr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);
endmodule

/* src/node_mem.sv */
`timescale 1ns/1ps

module node_mem (
	input  logic               clock,
	mem_if.mem                 mem,
	input  logic [10:0]        host_addr,
	input  logic               host_wr,
	input  routing_pkg::word_t host_wdata,
	output routing_pkg::word_t host_rdata
);
	logic [7:0] ram [2048];
	logic [10:0] mem_addr_hi;
	logic [10:0] host_addr_hi;

	assign mem_addr_hi = mem.addr + 11'd1; // high byte follows low byte
	assign host_addr_hi = host_addr + 11'd1;

	assign mem.rdata = {ram[mem_addr_hi], ram[mem.addr]};
	assign host_rdata = {ram[host_addr_hi], ram[host_addr]};

	always_ff @(posedge clock) begin
		if (host_wr) begin
			ram[host_addr] <= host_wdata[7:0];
			ram[host_addr_hi] <= host_wdata[15:8];
		end
		// assigned last so the update engine wins a collision
		if (mem.wr_en) begin
			ram[mem.addr] <= mem.wdata[7:0];
			ram[mem_addr_hi] <= mem.wdata[15:8];
		end
	end
endmodule

/* src/learn_costs.sv */
`timescale 1ns/1ps
`include "mem_map.svh"

module learn_costs (
	input  logic                   clock,
	input  logic                   nrst,
	input  logic                   not_empty,
	input  routing_pkg::feedback_t head,
	input  routing_pkg::word_t     epsilon_init,
	output logic                   pop,
	mem_if.ctrl                    mem,
	output logic                   busy,
	output logic                   done
);
	import routing_pkg::*;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_RD_NCNT, // latch neighbor count
		ST_RD_KCNT, // latch known-sink count
		ST_SEARCH,
		ST_CMP_ID,
		ST_APP_BAT,
		ST_APP_Q,
		ST_APP_CL,
		ST_SINK_ADDR, // sink list loop head
		ST_SINK_CP,
		ST_Q_ADDR,
		ST_Q_CMP,
		ST_NCNT_WR,
		ST_FINISH, // last write lands here
		ST_DONE
	} state_t;

	state_t state;
	feedback_t rec; // record being applied
	logic [NBR_IDX_W:0] ncnt; // clamped neighbor count
	logic [NBR_IDX_W:0] n; // search index
	logic [NBR_IDX_W-1:0] slot; // target neighbor slot
	logic [SINK_IDX_W:0] kcnt; // clamped known-sink count
	logic [SINK_IDX_W:0] k; // sink list index
	logic found;

	// base plus two bytes per index
	function automatic logic [10:0] word_addr(input logic [10:0] base, input logic [7:0] idx);
		word_addr = base + {2'b00, idx, 1'b0};
	endfunction

	// 16 bytes per neighbor, 2 per entry
	function automatic logic [10:0] sink_addr(input logic [NBR_IDX_W-1:0] nbr,
			input logic [SINK_IDX_W-1:0] entry);
		sink_addr = `SINK_IDS_BASE + 11'({nbr, entry, 1'b0});
	endfunction

	assign pop = (state == ST_IDLE) && not_empty;
	assign busy = (state != ST_IDLE) && (state != ST_DONE);
	assign done = (state == ST_DONE);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= ST_IDLE;
			mem.wr_en <= 1'b0;
			found <= 1'b0;
			n <= '0;
			k <= '0;
		end else begin
			mem.wr_en <= 1'b0; // writes last one cycle
			case (state)
				ST_IDLE: begin
					if (not_empty) begin
						rec <= head; // taken together with pop
						mem.addr <= `NEIGHBOR_COUNT_ADDR;
						state <= ST_RD_NCNT;
					end
				end
				ST_RD_NCNT: begin
					ncnt <= (mem.rdata > MAX_NEIGHBORS) ? (NBR_IDX_W + 1)'(MAX_NEIGHBORS)
						: mem.rdata[NBR_IDX_W:0];
					mem.addr <= `KNOWN_SINK_COUNT_ADDR;
					n <= '0;
					state <= ST_RD_KCNT;
				end
				ST_RD_KCNT: begin
					kcnt <= (mem.rdata > MAX_SINKS) ? (SINK_IDX_W + 1)'(MAX_SINKS)
						: mem.rdata[SINK_IDX_W:0];
					state <= ST_SEARCH;
				end
				ST_SEARCH: begin
					if (n == ncnt) begin
						if (ncnt == (NBR_IDX_W + 1)'(MAX_NEIGHBORS)) begin
							state <= ST_DONE; // table full, frame ignored
						end else begin
							mem.addr <= word_addr(`NEIGHBOR_ID_BASE, 8'(ncnt));
							mem.wdata <= rec.source_id;
							mem.wr_en <= 1'b1;
							slot <= ncnt[NBR_IDX_W-1:0];
							found <= 1'b0;
							state <= ST_APP_BAT;
						end
					end else begin
						mem.addr <= word_addr(`NEIGHBOR_ID_BASE, 8'(n));
						state <= ST_CMP_ID;
					end
				end
				ST_CMP_ID: begin
					if (mem.rdata == rec.source_id) begin // known neighbor
						mem.addr <= word_addr(`BATTERY_BASE, 8'(n));
						mem.wdata <= rec.battery_stat;
						mem.wr_en <= 1'b1;
						slot <= n[NBR_IDX_W-1:0];
						found <= 1'b1;
						k <= '0;
						state <= ST_SINK_ADDR;
					end else begin
						n <= n + 1'b1;
						state <= ST_SEARCH;
					end
				end
				ST_APP_BAT: begin
					mem.addr <= word_addr(`BATTERY_BASE, 8'(slot));
					mem.wdata <= rec.battery_stat;
					mem.wr_en <= 1'b1;
					state <= ST_APP_Q;
				end
				ST_APP_Q: begin
					mem.addr <= word_addr(`QVALUE_BASE, 8'(slot));
					mem.wdata <= rec.value;
					mem.wr_en <= 1'b1;
					state <= ST_APP_CL;
				end
				ST_APP_CL: begin
					mem.addr <= word_addr(`CLUSTER_ID_BASE, 8'(slot));
					mem.wdata <= rec.cluster_id;
					mem.wr_en <= 1'b1;
					k <= '0;
					state <= ST_SINK_ADDR;
				end
				ST_SINK_ADDR: begin
					if (k == kcnt) begin // list copied, store its length
						mem.addr <= word_addr(`SINK_ID_COUNT_BASE, 8'(slot));
						mem.wdata <= word_t'(kcnt);
						mem.wr_en <= 1'b1;
						state <= found ? ST_Q_ADDR : ST_NCNT_WR;
					end else begin
						mem.addr <= word_addr(`KNOWN_SINKS_BASE, 8'(k));
						state <= ST_SINK_CP;
					end
				end
				ST_SINK_CP: begin
					mem.addr <= sink_addr(slot, k[SINK_IDX_W-1:0]);
					mem.wdata <= mem.rdata; // known sink into neighbor list
					mem.wr_en <= 1'b1;
					k <= k + 1'b1;
					state <= ST_SINK_ADDR;
				end
				ST_Q_ADDR: begin
					mem.addr <= word_addr(`QVALUE_BASE, 8'(slot));
					state <= ST_Q_CMP;
				end
				ST_Q_CMP: begin
					if (mem.rdata < rec.value) begin // restore exploration
						mem.addr <= `EPSILON_ADDR;
						mem.wdata <= epsilon_init;
						mem.wr_en <= 1'b1;
						state <= ST_FINISH;
					end else begin
						state <= ST_DONE;
					end
				end
				ST_NCNT_WR: begin
					mem.addr <= `NEIGHBOR_COUNT_ADDR;
					mem.wdata <= word_t'(ncnt + 1'b1);
					mem.wr_en <= 1'b1;
					state <= ST_FINISH;
				end
				ST_FINISH: state <= ST_DONE;
				ST_DONE:   state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end
endmodule

/* src/record_fifo.sv */
`timescale 1ns/1ps

module record_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [63:0]
) (
	input  logic     clock,
	input  logic     nrst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     not_empty,
	output logic     overflow
);
	localparam int PTR_W = $clog2(DEPTH);

	payload_t buffer [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (PTR_W + 1)'(DEPTH));
	assign not_empty = (count != '0);
	assign do_push = push && !full;
	assign do_pop = pop && not_empty;
	assign head = buffer[rd_ptr]; // show-ahead

	always_ff @(posedge clock) begin
		if (do_push)
			buffer[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && full)
				overflow <= 1'b1; // record lost, held until reset
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end
endmodule

/* src/feedback_rx.sv */
`timescale 1ns/1ps

module feedback_rx (
	input  logic                   clock,
	input  logic                   nrst,
	input  logic                   rx_valid,
	input  logic                   rx_sof,
	input  routing_pkg::word_t     rx_word,
	output logic                   push,
	output routing_pkg::feedback_t record
);
	logic [1:0] idx; // position of the next word
	logic active; // inside a frame
	logic take;
	logic [1:0] field;

	assign take = rx_valid && (rx_sof || active); // stray words are dropped
	assign field = rx_sof ? 2'd0 : idx;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			idx <= 2'd0;
			active <= 1'b0;
			push <= 1'b0;
		end else begin
			push <= 1'b0;
			if (rx_valid && rx_sof) begin // restart, partial frame lost
				idx <= 2'd1;
				active <= 1'b1;
			end else if (rx_valid && active) begin
				idx <= idx + 2'd1;
				if (idx == 2'd3) begin
					active <= 1'b0;
					push <= 1'b1; // record complete
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			case (field)
				2'd0:    record.source_id <= rx_word;
				2'd1:    record.battery_stat <= rx_word;
				2'd2:    record.value <= rx_word;
				default: record.cluster_id <= rx_word;
			endcase
		end
	end
endmodule

/* src/mem_if.sv */
`timescale 1ns/1ps

interface mem_if;
	import routing_pkg::*;

	logic [10:0] addr; // byte address of the low byte
	logic wr_en;
	word_t wdata;
	word_t rdata; // combinational from addr

	modport ctrl (
		output addr,
		output wr_en,
		output wdata,
		input  rdata
	);

	modport mem (
		input  addr,
		input  wr_en,
		input  wdata,
		output rdata
	);
endinterface

/* src/routing_pkg.sv */
package routing_pkg;

	typedef logic [15:0] word_t; // one routing-table word

	// one feedback frame, in arrival order of its words
	typedef struct packed {
		word_t source_id;
		word_t battery_stat;
		word_t value; // reported q-value
		word_t cluster_id;
	} feedback_t;

	localparam int MAX_NEIGHBORS = 64; // neighbor table capacity
	localparam int MAX_SINKS = 8; // entries per sink list

	localparam int NBR_IDX_W = $clog2(MAX_NEIGHBORS);
	localparam int SINK_IDX_W = $clog2(MAX_SINKS);

endpackage

/* include/mem_map.svh */
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

`define EPSILON_ADDR          11'h004
`define KNOWN_SINKS_BASE      11'h008 // 2 per sink
`define NEIGHBOR_ID_BASE      11'h048 // 2 per neighbor
`define CLUSTER_ID_BASE       11'h0C8 // 2 per neighbor
`define BATTERY_BASE          11'h148 // 2 per neighbor
`define QVALUE_BASE           11'h1C8 // 2 per neighbor
`define SINK_IDS_BASE         11'h248 // 16 per neighbor, 2 per entry
`define KNOWN_SINK_COUNT_ADDR 11'h688
`define NEIGHBOR_COUNT_ADDR   11'h68A
`define SINK_ID_COUNT_BASE    11'h68E // 2 per neighbor

`endif
